//--- run_sim.sh
#!/bin/sh
# Compile the rotate checker and its testbench with Verilator, then run it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sources.f \
    --top-module z80fi_rot_checker_tb \
    -o z80fi_rot_checker_sim

./obj_dir/z80fi_rot_checker_sim 2>&1 | tee sim.log

if grep -q "^Simulation PASSED$" sim.log; then
    echo "run_sim: pass"
else
    echo "run_sim: fail, see sim.log"
    exit 1
fi

//--- sources.f
+incdir+.
z80fi_pkg.sv
z80fi_decode_stage.sv
z80fi_rot_stage.sv
z80fi_check_stage.sv
z80fi_rot_checker.sv
tb_clock_gen.sv
z80fi_rot_checker_props.sv
z80fi_rot_checker_tb.sv

//--- tb_clock_gen.sv
/*
 * Free-running testbench clock for the rotate checker, 8 ns period.
 */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk
);

    // Each phase lasts half of the 8 ns period.
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

endmodule

//--- z80fi_check_stage.sv
/*
 * Check stage of the rotate checker. Builds the register file the core
 * should report and flags applicable records whose claim differs from it.
 * All result outputs are registered.
 */
`timescale 1ns/1ps
`include "z80fi_macros.svh"

module z80fi_check_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  z80fi_pkg::rot_rec_t  rot,
    output logic                 result_valid,
    output logic                 result_applies,
    output logic                 result_mismatch,
    output z80fi_pkg::z80_regs_t spec_regs
);
    import z80fi_pkg::*;

    z80_regs_t exp_regs;
    logic      mismatch;

    always_comb begin
        exp_regs    = rot.regs_in;
        exp_regs.ip = rot.regs_in.ip + 16'd2;
        exp_regs.f  = rot.f_new;

        // Only the rotated register changes besides IP and F.
        case (rot.r)
            `REG_B:  exp_regs.b = rot.wdata;
            `REG_C:  exp_regs.c = rot.wdata;
            `REG_D:  exp_regs.d = rot.wdata;
            `REG_E:  exp_regs.e = rot.wdata;
            `REG_H:  exp_regs.h = rot.wdata;
            `REG_L:  exp_regs.l = rot.wdata;
            `REG_A:  exp_regs.a = rot.wdata;
            default: exp_regs.a = rot.regs_in.a;
        endcase
    end

    // Records that are not rotates are never reported as mismatches.
    assign mismatch = rot.applies && (rot.regs_claim != exp_regs);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_valid    <= 1'b0;
            result_applies  <= 1'b0;
            result_mismatch <= 1'b0;
        end else begin
            result_valid    <= rot.valid;
            result_applies  <= rot.applies;
            result_mismatch <= mismatch;
        end
    end

    always_ff @(posedge clk) begin
        spec_regs <= exp_regs;
    end

endmodule

//--- z80fi_decode_stage.sv
/*
 * Decode stage of the rotate checker. Takes a trace record every clock,
 * decides whether it is a CB register rotate and fetches the source register.
 * The decoded record leaves one cycle later.
 */
`timescale 1ns/1ps
`include "z80fi_macros.svh"

module z80fi_decode_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  z80fi_pkg::z80fi_trace_t trace,
    output z80fi_pkg::dec_rec_t     dec
);
    import z80fi_pkg::*;

    dec_rec_t dec_d;
    logic     is_rotate;

    // A rotate is CB followed by 00 t d rrr, and r = 6 would be (HL).
    assign is_rotate = trace.insn_len == `ROT_INSN_LEN &&
                       trace.insn.bytes.prefix == `CB_PREFIX &&
                       trace.insn.rot.grp == 3'b000 &&
                       trace.insn.rot.r != `REG_MEM;

    always_comb begin
        dec_d.valid      = trace.valid;
        dec_d.applies    = trace.valid && is_rotate;
        dec_d.through_c  = trace.insn.rot.through_c;
        dec_d.right      = trace.insn.rot.right;
        dec_d.r          = trace.insn.rot.r;
        dec_d.regs_in    = trace.regs_in;
        dec_d.regs_claim = trace.regs_claim;

        case (trace.insn.rot.r)
            `REG_B:  dec_d.rdata = trace.regs_in.b;
            `REG_C:  dec_d.rdata = trace.regs_in.c;
            `REG_D:  dec_d.rdata = trace.regs_in.d;
            `REG_E:  dec_d.rdata = trace.regs_in.e;
            `REG_H:  dec_d.rdata = trace.regs_in.h;
            `REG_L:  dec_d.rdata = trace.regs_in.l;
            `REG_A:  dec_d.rdata = trace.regs_in.a;
            default: dec_d.rdata = 8'h00;
        endcase
    end

    // Only the valid and applies bits are cleared by reset.
    always_ff @(posedge clk) begin
        dec <= dec_d;
        if (!rst_n) begin
            dec.valid   <= 1'b0;
            dec.applies <= 1'b0;
        end
    end

endmodule

//--- z80fi_macros.svh
/*
 * Fixed Z80 encodings shared by the rotate checker stages and the testbench model.
 * Holds register codes, flag bit positions, the CB prefix byte and the rotate length.
 */
`ifndef Z80FI_MACROS_SVH
`define Z80FI_MACROS_SVH

// Register codes as they appear in the r field of the opcode.
`define REG_B 3'd0
`define REG_C 3'd1
`define REG_D 3'd2
`define REG_E 3'd3
`define REG_H 3'd4
`define REG_L 3'd5
`define REG_MEM 3'd6
`define REG_A 3'd7

// Bit positions inside the F register.
`define FLAG_C_NUM 0
`define FLAG_N_NUM 1
`define FLAG_V_NUM 2
`define FLAG_3_NUM 3
`define FLAG_H_NUM 4
`define FLAG_5_NUM 5
`define FLAG_Z_NUM 6
`define FLAG_S_NUM 7

`define CB_PREFIX 8'hCB
`define ROT_INSN_LEN 4'd2

`endif

//--- z80fi_pkg.sv
/*
 * Types for the CB rotate trace checker: the instruction word, the register
 * file, the trace record from the core and the records passed between stages.
 */
package z80fi_pkg;

    // Instruction word seen as the two raw bytes in memory order.
    typedef struct packed {
        logic [7:0] opcode;
        logic [7:0] prefix;
    } insn_bytes_t;

    // The same word split into the fields of the CB rotate group.
    typedef struct packed {
        logic [2:0] grp;
        logic       through_c;
        logic       right;
        logic [2:0] r;
        logic [7:0] prefix;
    } insn_rot_t;

    typedef union packed {
        insn_bytes_t bytes;
        insn_rot_t   rot;
    } insn_word_u;

    typedef struct packed {
        logic [15:0] ip;
        logic [7:0]  a;
        logic [7:0]  f;
        logic [7:0]  b;
        logic [7:0]  c;
        logic [7:0]  d;
        logic [7:0]  e;
        logic [7:0]  h;
        logic [7:0]  l;
    } z80_regs_t;

    // One retired instruction as reported by the core.
    typedef struct packed {
        logic       valid;
        insn_word_u insn;
        logic [3:0] insn_len;
        z80_regs_t  regs_in;
        z80_regs_t  regs_claim;
    } z80fi_trace_t;

    typedef struct packed {
        logic       valid;
        logic       applies;
        logic       through_c;
        logic       right;
        logic [2:0] r;
        logic [7:0] rdata;
        z80_regs_t  regs_in;
        z80_regs_t  regs_claim;
    } dec_rec_t;

    typedef struct packed {
        logic       valid;
        logic       applies;
        logic [2:0] r;
        logic [7:0] wdata;
        logic [7:0] f_new;
        z80_regs_t  regs_in;
        z80_regs_t  regs_claim;
    } rot_rec_t;

endpackage

//--- z80fi_rot_checker.sv
/*
 * Trace checker for the Z80 CB register rotates. Chains decode, rotate and
 * check stages; every record yields a result exactly three cycles later.
 */
`timescale 1ns/1ps

module z80fi_rot_checker (
    input  logic                    clk,
    input  logic                    rst_n,
    input  z80fi_pkg::z80fi_trace_t trace,
    output logic                    result_valid,
    output logic                    result_applies,
    output logic                    result_mismatch,
    output z80fi_pkg::z80_regs_t    spec_regs
);
    import z80fi_pkg::*;

    dec_rec_t dec;
    rot_rec_t rot;

    z80fi_decode_stage z80fi_decode_stage_i (
        .clk   (clk),
        .rst_n (rst_n),
        .trace (trace),
        .dec   (dec)
    );

    z80fi_rot_stage z80fi_rot_stage_i (
        .clk   (clk),
        .rst_n (rst_n),
        .dec   (dec),
        .rot   (rot)
    );

    z80fi_check_stage z80fi_check_stage_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .rot             (rot),
        .result_valid    (result_valid),
        .result_applies  (result_applies),
        .result_mismatch (result_mismatch),
        .spec_regs       (spec_regs)
    );

endmodule

//--- z80fi_rot_checker_props.sv
/*
 * Assertions bound to the rotate checker top level. They check the fixed
 * three-cycle latency, quiet outputs under reset and a consistent mismatch flag.
 */
`timescale 1ns/1ps

module z80fi_rot_checker_props (
    input logic clk,
    input logic rst_n,
    input logic trace_valid,
    input logic result_valid,
    input logic result_applies,
    input logic result_mismatch
);

    // A record only reaches the output if all three stages saw reset released.
    latency_a: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(rst_n, 1) && $past(rst_n, 2) && $past(rst_n, 3)) |->
            (result_valid == $past(trace_valid, 3)))
        else $error("result_valid does not follow trace.valid by three cycles");

    reset_quiet_a: assert property (@(posedge clk)
        !rst_n |=> (!result_valid && !result_applies && !result_mismatch))
        else $error("result outputs are not low after a reset cycle");

    mismatch_a: assert property (@(posedge clk) disable iff (!rst_n)
        result_mismatch |-> (result_valid && result_applies))
        else $error("result_mismatch is high without a valid applicable result");

endmodule

bind z80fi_rot_checker z80fi_rot_checker_props z80fi_rot_checker_props_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .trace_valid     (trace.valid),
    .result_valid    (result_valid),
    .result_applies  (result_applies),
    .result_mismatch (result_mismatch)
);

//--- z80fi_rot_checker_tb.sv
/*
 * Testbench for the CB rotate trace checker. Sends random trace records with
 * gaps and bursts, predicts every result with its own rotate model and checks
 * order, latency, flags and spec_regs. A reset is applied in the middle of traffic.
 */
`timescale 1ns/1ps
`include "z80fi_macros.svh"

module z80fi_rot_checker_tb;
    import z80fi_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int MID_RESET_CYCLES = 5;
    localparam int MAIN_SLOTS = 600;
    localparam int TAIL_SLOTS = 200;
    localparam int WATCHDOG_CYCLES = MAIN_SLOTS + TAIL_SLOTS + RESET_CYCLES +
                                     MID_RESET_CYCLES + 100;
    // Of the three records sent just before the mid-traffic reset, the
    // first leaves the pipeline in time and the last two are still inside.
    localparam int LOST_AT_RESET = 2;

    typedef struct packed {
        logic [1:0]  kind;
        logic        applies;
        logic        mismatch;
        z80_regs_t   regs;
        logic [31:0] stamp;
    } exp_rec_t;

    logic         clk;
    logic         rst_n;
    z80fi_trace_t trace;
    logic         result_valid;
    logic         result_applies;
    logic         result_mismatch;
    z80_regs_t    spec_regs;
    logic [31:0]  cycle;
    exp_rec_t     expected_q[$];
    int           sent_count;
    int           result_count;

    tb_clock_gen tb_clock_gen_i (
        .clk (clk)
    );

    z80fi_rot_checker z80fi_rot_checker_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .trace           (trace),
        .result_valid    (result_valid),
        .result_applies  (result_applies),
        .result_mismatch (result_mismatch),
        .spec_regs       (spec_regs)
    );

    always @(posedge clk) begin
        cycle <= cycle + 32'd1;
    end

    task automatic check_value(input string name, input logic [79:0] expected,
                               input logic [79:0] actual);
        if (actual !== expected) begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    function automatic string kind_name(input logic [1:0] kind);
        case (kind)
            2'd0:    return "rotate";
            2'd1:    return "flipped_claim";
            default: return "not_applicable";
        endcase
    endfunction

    // Reference model of RLC, RRC, RL and RR written as nine-bit rotates.
    function automatic exp_rec_t model_record(input z80fi_trace_t t);
        exp_rec_t   e;
        logic [7:0] op;
        logic [7:0] src;
        logic [7:0] res;
        logic       cout;
        logic       par;
        z80_regs_t  x;

        op = t.insn.bytes.opcode;
        x = t.regs_in;
        e = '0;
        e.applies = (t.insn_len == `ROT_INSN_LEN) && (t.insn.bytes.prefix == `CB_PREFIX) &&
                    (op[7:5] == 3'b000) && (op[2:0] != `REG_MEM);
        case (op[2:0])
            `REG_B:  src = x.b;
            `REG_C:  src = x.c;
            `REG_D:  src = x.d;
            `REG_E:  src = x.e;
            `REG_H:  src = x.h;
            `REG_L:  src = x.l;
            default: src = x.a;
        endcase
        case (op[4:3])
            2'b00:   {cout, res} = {src, src[7]};
            2'b01:   {res, cout} = {src[0], src};
            2'b10:   {cout, res} = {src, x.f[`FLAG_C_NUM]};
            default: {res, cout} = {x.f[`FLAG_C_NUM], src};
        endcase
        // V is set when the result holds an even number of ones.
        par = 1'b1;
        for (int i = 0; i < 8; i++) begin
            par = par ^ res[i];
        end
        x.f[`FLAG_S_NUM] = res[7];
        x.f[`FLAG_Z_NUM] = (res == 8'h00);
        x.f[`FLAG_H_NUM] = 1'b0;
        x.f[`FLAG_V_NUM] = par;
        x.f[`FLAG_N_NUM] = 1'b0;
        x.f[`FLAG_C_NUM] = cout;
        case (op[2:0])
            `REG_B:  x.b = res;
            `REG_C:  x.c = res;
            `REG_D:  x.d = res;
            `REG_E:  x.e = res;
            `REG_H:  x.h = res;
            `REG_L:  x.l = res;
            default: x.a = res;
        endcase
        x.ip = x.ip + 16'd2;
        e.regs = x;
        e.mismatch = e.applies && (t.regs_claim != x);
        return e;
    endfunction

    function automatic z80fi_trace_t make_record(input logic [1:0] kind);
        z80fi_trace_t t;
        exp_rec_t     e;
        logic [2:0]   r;

        t = '0;
        t.valid = 1'b1;
        t.regs_in = 80'({$urandom, $urandom, $urandom});
        r = 3'($urandom_range(0, 6));
        if (r == `REG_MEM) begin
            r = `REG_A;
        end
        t.insn.rot.prefix = `CB_PREFIX;
        t.insn.rot.through_c = 1'($urandom_range(0, 1));
        t.insn.rot.right = 1'($urandom_range(0, 1));
        t.insn.rot.r = r;
        t.insn_len = `ROT_INSN_LEN;
        if (kind == 2'd2) begin
            // Break exactly one of the conditions for a register rotate.
            case ($urandom_range(0, 3))
                0:       t.insn.rot.r = `REG_MEM;
                1:       t.insn.bytes.prefix = `CB_PREFIX ^ 8'($urandom_range(1, 255));
                2:       t.insn_len = `ROT_INSN_LEN ^ 4'($urandom_range(1, 15));
                default: t.insn.rot.grp = 3'($urandom_range(1, 7));
            endcase
            t.regs_claim = 80'({$urandom, $urandom, $urandom});
        end else begin
            e = model_record(t);
            t.regs_claim = e.regs;
            if (kind == 2'd1) begin
                t.regs_claim = t.regs_claim ^ (80'd1 << $urandom_range(0, 79));
            end
        end
        return t;
    endfunction

    task automatic send_record();
        z80fi_trace_t rec;
        exp_rec_t     e;
        logic [1:0]   kind;
        int unsigned  pick;

        pick = $urandom_range(0, 9);
        kind = (pick < 6) ? 2'd0 : ((pick < 8) ? 2'd1 : 2'd2);
        rec = make_record(kind);
        e = model_record(rec);
        e.kind = kind;
        @(posedge clk);
        // The counter still holds the previous edge while this one is processed.
        e.stamp = cycle + 32'd1;
        trace <= rec;
        expected_q.push_back(e);
        sent_count++;
    endtask

    task automatic run_traffic(input int slots);
        int burst;

        burst = 0;
        repeat (slots) begin
            if (burst == 0 && $urandom_range(0, 7) == 0) begin
                burst = int'($urandom_range(4, 16));
            end
            if (burst > 0 || $urandom_range(0, 1) == 1) begin
                burst = (burst > 0) ? burst - 1 : 0;
                send_record();
            end else begin
                @(posedge clk);
                trace.valid <= 1'b0;
            end
        end
    endtask

    // Results appear at the falling edge three cycles after the driving edge.
    always @(negedge clk) begin
        exp_rec_t e;
        if (result_valid) begin
            if (expected_q.size() == 0) begin
                $display("A result appeared with no record outstanding at cycle %0d", cycle);
                $display("Simulation FAILED");
                $fatal(1);
            end else begin
                e = expected_q.pop_front();
                result_count++;
                check_value({kind_name(e.kind), " latency"}, 80'd3, 80'(cycle - e.stamp));
                check_value({kind_name(e.kind), " applies"}, 80'(e.applies),
                            80'(result_applies));
                check_value({kind_name(e.kind), " mismatch"}, 80'(e.mismatch),
                            80'(result_mismatch));
                if (e.applies) begin
                    check_value({kind_name(e.kind), " spec_regs"}, e.regs, spec_regs);
                end
            end
        end
        // Records still in the pipeline are lost when reset is seen.
        if (!rst_n) begin
            expected_q.delete();
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * 8);
        $display("Watchdog timeout: the traffic did not complete in time");
        $display("Simulation FAILED");
        $fatal(1);
    end

    initial begin
        void'($urandom(32'h1a5d));
        rst_n = 1'b0;
        trace = '0;
        cycle = 32'd0;
        sent_count = 0;
        result_count = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        run_traffic(MAIN_SLOTS);

        // Keep three records in flight, then reset on top of them.
        repeat (3) send_record();
        @(posedge clk);
        trace <= '0;
        rst_n <= 1'b0;
        repeat (MID_RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        run_traffic(TAIL_SLOTS);

        @(posedge clk);
        trace.valid <= 1'b0;
        wait (expected_q.size() == 0);
        repeat (6) @(posedge clk);
        check_value("result count", 80'(sent_count - LOST_AT_RESET), 80'(result_count));
        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- z80fi_rot_stage.sv
/*
 * Rotate stage of the checker. Computes the rotated byte and the new F
 * for RLC, RRC, RL and RR from the decoded record, one cycle of latency.
 */
`timescale 1ns/1ps
`include "z80fi_macros.svh"

module z80fi_rot_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  z80fi_pkg::dec_rec_t dec,
    output z80fi_pkg::rot_rec_t rot
);
    import z80fi_pkg::*;

    rot_rec_t   rot_d;
    logic       out_bit;
    logic       shove_bit;
    logic [7:0] wdata;
    logic [7:0] f_new;

    // The bit that falls off the end always becomes the new carry.
    assign out_bit = dec.right ? dec.rdata[0] : dec.rdata[7];

    // RL and RR shift the old carry in, so they act as nine-bit rotates.
    assign shove_bit = dec.through_c ? dec.regs_in.f[`FLAG_C_NUM] : out_bit;

    assign wdata = dec.right ? {shove_bit, dec.rdata[7:1]} : {dec.rdata[6:0], shove_bit};

    always_comb begin
        // Undocumented bits 5 and 3 come straight from the old F.
        f_new = dec.regs_in.f;
        f_new[`FLAG_S_NUM] = wdata[7];
        f_new[`FLAG_Z_NUM] = (wdata == 8'h00);
        f_new[`FLAG_H_NUM] = 1'b0;
        f_new[`FLAG_V_NUM] = ~^wdata;
        f_new[`FLAG_N_NUM] = 1'b0;
        f_new[`FLAG_C_NUM] = out_bit;
    end

    always_comb begin
        rot_d.valid      = dec.valid;
        rot_d.applies    = dec.applies;
        rot_d.r          = dec.r;
        rot_d.wdata      = wdata;
        rot_d.f_new      = f_new;
        rot_d.regs_in    = dec.regs_in;
        rot_d.regs_claim = dec.regs_claim;
    end

    always_ff @(posedge clk) begin
        rot <= rot_d;
        if (!rst_n) begin
            rot.valid   <= 1'b0;
            rot.applies <= 1'b0;
        end
    end

endmodule
